// File: logic/idma_xif_pkg.sv
// DMA instruction front end definitions
`default_nettype none

package idma_xif_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned INSTR_W     = 32;
  localparam int unsigned DATA_W      = 32;  // Operand and register width
  localparam int unsigned ADDR_W      = 8;   // Register bus byte address
  localparam int unsigned OPCODE_W    = 7;
  localparam int unsigned FUNC3_W     = 3;
  localparam int unsigned LOG_LEN_W   = 3;   // Max log burst length fields
  localparam int unsigned CONF_W      = 10;  // Packed CONF word
  localparam int unsigned N_CFG_WORDS = 7;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction field offsets
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned OPCODE_OFF          = 0;
  localparam int unsigned ND_EN_OFF           = 7;
  localparam int unsigned FUNC3_OFF           = 12;
  localparam int unsigned DST_MAX_LOG_LEN_OFF = 15;
  localparam int unsigned SRC_MAX_LOG_LEN_OFF = 20;
  localparam int unsigned DECOUPLE_R_W_OFF    = 25;
  localparam int unsigned DECOUPLE_R_AW_OFF   = 26;
  localparam int unsigned DIRECTION_OFF       = 27;

  // Direction sits on top of the packed CONF word
  localparam int unsigned CONF_DIR_BIT = 9;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Front-end register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [ADDR_W-1:0] REG_CONF_ADDR    = 8'h00;
  localparam logic [ADDR_W-1:0] REG_DST_LO_ADDR  = 8'h04;
  localparam logic [ADDR_W-1:0] REG_DST_HI_ADDR  = 8'h08;
  localparam logic [ADDR_W-1:0] REG_SRC_LO_ADDR  = 8'h0C;
  localparam logic [ADDR_W-1:0] REG_SRC_HI_ADDR  = 8'h10;
  localparam logic [ADDR_W-1:0] REG_LEN_LO_ADDR  = 8'h14;
  localparam logic [ADDR_W-1:0] REG_LEN_HI_ADDR  = 8'h18;
  localparam logic [ADDR_W-1:0] REG_NEXT_ID_ADDR = 8'h1C;  // Read only, transfer ID

  typedef enum logic [OPCODE_W-1:0] {
    OPC_CONF = 7'b0001011,
    OPC_SET  = 7'b0101011
  } xif_opcode_e;

  // Sub-functions of SET
  typedef enum logic [FUNC3_W-1:0] {
    F3_DST   = 3'd0,
    F3_SRC   = 3'd1,
    F3_LEN   = 3'd2,
    F3_START = 3'd7
  } set_func3_e;

  // Bank word index, low word of each pair directly below its high word
  typedef enum logic [2:0] {
    W_CONF, W_DST_LO, W_DST_HI, W_SRC_LO, W_SRC_HI, W_LEN_LO, W_LEN_HI
  } cfg_word_e;

endpackage

`default_nettype wire

// File: logic/xif_inst_decoder.sv
// Custom instruction decoder
`default_nettype none

module xif_inst_decoder import idma_xif_pkg::*; (
  input  wire logic              issue_valid_i,
  input  wire logic              rs_valid_i,
  input  wire logic [INSTR_W-1:0] instr_i,
  input  wire logic [DATA_W-1:0] rs0_i,
  input  wire logic [DATA_W-1:0] rs1_i,
  output logic                   issue_ready_o,
  output logic                   accept_o,
  output logic                   conf_we_o,
  output logic [CONF_W-1:0]      conf_o,
  output logic                   pair_we_o,
  output cfg_word_e              pair_sel_o,
  output logic [DATA_W-1:0]      lo_o,
  output logic [DATA_W-1:0]      hi_o,
  output logic                   start_o
);

  xif_opcode_e           opcode;
  set_func3_e            func3;
  logic                  nd_en;
  logic [LOG_LEN_W-1:0]  dst_max_log_len;
  logic [LOG_LEN_W-1:0]  src_max_log_len;
  logic                  decouple_r_w;
  logic                  decouple_r_aw;
  logic                  direction;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field extraction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign opcode          = xif_opcode_e'(instr_i[OPCODE_OFF +: OPCODE_W]);
  assign func3           = set_func3_e'(instr_i[FUNC3_OFF +: FUNC3_W]);
  assign nd_en           = instr_i[ND_EN_OFF];
  assign dst_max_log_len = instr_i[DST_MAX_LOG_LEN_OFF +: LOG_LEN_W];
  assign src_max_log_len = instr_i[SRC_MAX_LOG_LEN_OFF +: LOG_LEN_W];
  assign decouple_r_w    = instr_i[DECOUPLE_R_W_OFF];
  assign decouple_r_aw   = instr_i[DECOUPLE_R_AW_OFF];
  assign direction       = instr_i[DIRECTION_OFF];

  // Packed from bit 0 upward, direction lands on CONF_DIR_BIT
  assign conf_o = {direction, decouple_r_aw, decouple_r_w,
                   src_max_log_len, dst_max_log_len, nd_en};

  // Operands pass straight to the bank
  assign lo_o = rs0_i;
  assign hi_o = rs1_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Acceptance and dispatch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    accept_o   = 1'b0;
    conf_we_o  = 1'b0;
    pair_we_o  = 1'b0;
    pair_sel_o = W_DST_LO;
    start_o    = 1'b0;

    if (issue_valid_i) begin
      case (opcode)
        OPC_CONF: begin
          accept_o  = 1'b1;
          conf_we_o = 1'b1;
        end
        OPC_SET: begin
          accept_o = 1'b1;
          case (func3)
            F3_DST:   begin pair_sel_o = W_DST_LO; pair_we_o = rs_valid_i; end
            F3_SRC:   begin pair_sel_o = W_SRC_LO; pair_we_o = rs_valid_i; end
            F3_LEN:   begin pair_sel_o = W_LEN_LO; pair_we_o = rs_valid_i; end
            F3_START: start_o = 1'b1;  // Operands not needed
            default:  ;                // Accepted, no effect
          endcase
        end
        default: ;  // Unknown opcode left to other coprocessors
      endcase
    end
  end

  assign issue_ready_o = accept_o;  // No back-pressure

  // An instruction is only taken while the core offers one
  always_comb begin
    a_accept_needs_valid: assert (!accept_o || issue_valid_i)
      else $error("accept_o high without issue_valid_i");
  end

endmodule

`default_nettype wire

// File: logic/dma_cfg_bank.sv
// DMA configuration register bank
`default_nettype none

module dma_cfg_bank import idma_xif_pkg::*; (
  input  wire logic              clk_cfg_g,
  input  wire logic              rst_ni,
  input  wire logic              clear_i,
  input  wire logic              conf_we_i,
  input  wire logic              pair_we_i,
  input  wire logic [CONF_W-1:0] conf_i,
  input  wire cfg_word_e         pair_sel_i,
  input  wire cfg_word_e         rd_idx_i,
  input  wire logic [DATA_W-1:0] lo_i,
  input  wire logic [DATA_W-1:0] hi_i,
  output logic [DATA_W-1:0]      rd_data_o,
  output logic                   direction_o
);

  logic [DATA_W-1:0] words_q [N_CFG_WORDS];
  logic [2:0]        hi_idx;

  // High word of a pair always follows its low word
  assign hi_idx = pair_sel_i + 3'd1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < N_CFG_WORDS; i++) begin
        words_q[i] <= '0;
      end
    end else if (clear_i) begin
      for (int i = 0; i < N_CFG_WORDS; i++) begin
        words_q[i] <= '0;
      end
    end else begin
      if (conf_we_i) begin
        words_q[W_CONF] <= {{(DATA_W-CONF_W){1'b0}}, conf_i};  // Upper bits stay zero
      end
      if (pair_we_i) begin
        words_q[pair_sel_i] <= lo_i;
        words_q[hi_idx]     <= hi_i;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rd_data_o   = words_q[rd_idx_i];              // Selected by the FSM
  assign direction_o = words_q[W_CONF][CONF_DIR_BIT];  // 1 -> OBI to AXI

  // One instruction per cycle, so the decoder never asks for both writes
  a_single_write: assert property (
    @(posedge clk_cfg_g) disable iff (!rst_ni)
    !(conf_we_i && pair_we_i)
  ) else $error("CONF and pair write in the same cycle");

endmodule

`default_nettype wire

// File: logic/fe_program_fsm.sv
// DMA front-end programming FSM
`default_nettype none

module fe_program_fsm import idma_xif_pkg::*; (
  input  wire logic              clk_cfg_g,
  input  wire logic              rst_ni,
  input  wire logic              clear_i,
  input  wire logic              start_i,
  input  wire logic [DATA_W-1:0] rd_data_i,
  input  wire logic              reg_ready_i,
  input  wire logic              reg_error_i,
  input  wire logic [DATA_W-1:0] reg_rdata_i,
  output cfg_word_e              rd_idx_o,
  output logic                   reg_valid_o,
  output logic                   reg_write_o,
  output logic [ADDR_W-1:0]      reg_addr_o,
  output logic [DATA_W-1:0]      reg_wdata_o,
  output logic                   start_o,
  output logic                   busy_o,
  output logic                   done_o,
  output logic                   error_o
);

  // Write states are consecutive so the sequence can step by one
  typedef enum logic [3:0] {
    IDLE,
    WR_CONF, WR_DST_LO, WR_DST_HI, WR_SRC_LO, WR_SRC_HI, WR_LEN_LO, WR_LEN_HI,
    START,
    BUSY,
    DONE
  } fsm_state_e;

  fsm_state_e        state_q, state_d;
  logic [DATA_W-1:0] id_q;     // Transfer ID seen at launch
  logic [DATA_W-1:0] wdata_q;  // Write data frozen during a stall
  logic              hold_q;
  logic              is_write;
  logic              ack;
  logic              bus_err;
  logic              id_zero;
  logic              id_store;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rd_idx_o   = W_CONF;
    reg_addr_o = REG_CONF_ADDR;
    case (state_q)
      WR_CONF:     begin rd_idx_o = W_CONF;   reg_addr_o = REG_CONF_ADDR;   end
      WR_DST_LO:   begin rd_idx_o = W_DST_LO; reg_addr_o = REG_DST_LO_ADDR; end
      WR_DST_HI:   begin rd_idx_o = W_DST_HI; reg_addr_o = REG_DST_HI_ADDR; end
      WR_SRC_LO:   begin rd_idx_o = W_SRC_LO; reg_addr_o = REG_SRC_LO_ADDR; end
      WR_SRC_HI:   begin rd_idx_o = W_SRC_HI; reg_addr_o = REG_SRC_HI_ADDR; end
      WR_LEN_LO:   begin rd_idx_o = W_LEN_LO; reg_addr_o = REG_LEN_LO_ADDR; end
      WR_LEN_HI:   begin rd_idx_o = W_LEN_HI; reg_addr_o = REG_LEN_HI_ADDR; end
      START, BUSY: reg_addr_o = REG_NEXT_ID_ADDR;  // ID polling
      default:     ;
    endcase
  end

  assign is_write    = (state_q >= WR_CONF) && (state_q <= WR_LEN_HI);
  assign reg_valid_o = is_write || (state_q == START) || (state_q == BUSY);
  assign reg_write_o = is_write;
  assign reg_wdata_o = !is_write ? '0 : (hold_q ? wdata_q : rd_data_i);

  assign ack      = reg_valid_o && reg_ready_i;
  assign bus_err  = ack && reg_error_i;
  assign id_zero  = ack && !reg_error_i && (state_q == START) && (reg_rdata_i == '0);
  assign id_store = ack && !reg_error_i &&
                    (((state_q == START) && !id_zero) ||
                     ((state_q == BUSY) && (reg_rdata_i == id_q)));

  assign start_o = (state_q == START);
  assign busy_o  = (state_q == BUSY);
  assign done_o  = (state_q == DONE);
  assign error_o = bus_err || id_zero;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) state_d = WR_CONF;
      end
      START: begin
        if (ack) state_d = (reg_error_i || id_zero) ? IDLE : BUSY;
      end
      BUSY: begin
        // A new ID means our transfer has retired
        if (ack) state_d = reg_error_i ? IDLE : ((reg_rdata_i != id_q) ? DONE : BUSY);
      end
      DONE: state_d = IDLE;
      default: begin
        if (ack) state_d = reg_error_i ? IDLE : fsm_state_e'(state_q + 4'd1);
      end
    endcase
  end

  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      id_q    <= '0;
      hold_q  <= 1'b0;
    end else if (clear_i) begin
      state_q <= IDLE;
      id_q    <= '0;
      hold_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      hold_q  <= is_write && !reg_ready_i;  // Stalled write keeps its data
      if (id_store) id_q <= reg_rdata_i;
    end
  end

  // Captured on the first stall cycle only
  always_ff @(posedge clk_cfg_g) begin
    if (is_write && !reg_ready_i && !hold_q) wdata_q <= rd_data_i;
  end

  // Bank updates during a stall must not reach the bus
  a_req_stable: assert property (
    @(posedge clk_cfg_g) disable iff (!rst_ni)
    (reg_valid_o && !reg_ready_i && !clear_i) |=>
      ($stable(reg_addr_o) && $stable(reg_wdata_o))
  ) else $error("Register request changed while stalled");

endmodule

`default_nettype wire

// File: logic/idma_xif_ctrl.sv
// DMA instruction front end top
`default_nettype none

module idma_xif_ctrl import idma_xif_pkg::*; (
  input  wire logic               clk_cfg_g,
  input  wire logic               rst_ni,
  input  wire logic               clear_i,
  // Processor issue side
  input  wire logic               issue_valid_i,
  input  wire logic               rs_valid_i,
  input  wire logic [INSTR_W-1:0] instr_i,
  input  wire logic [DATA_W-1:0]  rs0_i,
  input  wire logic [DATA_W-1:0]  rs1_i,
  output logic                    issue_ready_o,
  output logic                    accept_o,
  // Front-end register bus
  input  wire logic               reg_ready_i,
  input  wire logic               reg_error_i,
  input  wire logic [DATA_W-1:0]  reg_rdata_i,
  output logic                    reg_valid_o,
  output logic                    reg_write_o,
  output logic [ADDR_W-1:0]       reg_addr_o,
  output logic [DATA_W-1:0]       reg_wdata_o,
  // Status
  output logic                    direction_o,
  output logic                    start_o,
  output logic                    busy_o,
  output logic                    done_o,
  output logic                    error_o
);

  logic              conf_we;
  logic [CONF_W-1:0] conf;
  logic              pair_we;
  cfg_word_e         pair_sel;
  logic [DATA_W-1:0] pair_lo;
  logic [DATA_W-1:0] pair_hi;
  logic              start_req;  // From SET start
  cfg_word_e         rd_idx;
  logic [DATA_W-1:0] rd_data;

  xif_inst_decoder u_decoder (
    .issue_valid_i, .rs_valid_i, .instr_i, .rs0_i, .rs1_i,
    .issue_ready_o, .accept_o,
    .conf_we_o  (conf_we),
    .conf_o     (conf),
    .pair_we_o  (pair_we),
    .pair_sel_o (pair_sel),
    .lo_o       (pair_lo),
    .hi_o       (pair_hi),
    .start_o    (start_req)
  );

  dma_cfg_bank u_bank (
    .clk_cfg_g, .rst_ni, .clear_i,
    .conf_we_i  (conf_we),
    .pair_we_i  (pair_we),
    .conf_i     (conf),
    .pair_sel_i (pair_sel),
    .rd_idx_i   (rd_idx),
    .lo_i       (pair_lo),
    .hi_i       (pair_hi),
    .rd_data_o  (rd_data),
    .direction_o
  );

  fe_program_fsm u_fsm (
    .clk_cfg_g, .rst_ni, .clear_i,
    .start_i   (start_req),
    .rd_data_i (rd_data),
    .reg_ready_i, .reg_error_i, .reg_rdata_i,
    .rd_idx_o  (rd_idx),
    .reg_valid_o, .reg_write_o, .reg_addr_o, .reg_wdata_o,
    .start_o, .busy_o, .done_o, .error_o
  );

endmodule

`default_nettype wire

// File: verification/fe_reg_model.sv
// Front-end register responder
`default_nettype none

module fe_reg_model import idma_xif_pkg::*; (
  input  wire logic              clk_cfg_g,
  input  wire logic              rst_ni,
  input  wire logic              reg_valid_i,
  input  wire logic              reg_write_i,
  input  wire logic [ADDR_W-1:0] reg_addr_i,
  input  wire logic              err_en_i,     // Fail accesses to err_addr_i
  input  wire logic [ADDR_W-1:0] err_addr_i,
  input  wire logic              zero_id_i,    // NEXT_ID reads return zero
  input  wire logic [7:0]        adv_after_i,  // Reads before the ID moves, 0 never
  output logic                   reg_ready_o,
  output logic                   reg_error_o,
  output logic [DATA_W-1:0]      reg_rdata_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int                seed = 32'h742fb6b5;
  int                rnd;
  logic [1:0]        stall_q;   // Wait cycles left on the current request
  logic [7:0]        rd_cnt_q;
  logic [DATA_W-1:0] id_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write log
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  int unsigned       log_cnt;

  assign reg_ready_o = reg_valid_i && (stall_q == 2'd0);
  assign reg_error_o = reg_ready_o && err_en_i && (reg_addr_i == err_addr_i);
  assign reg_rdata_o = zero_id_i ? '0 : id_q;

  always @(posedge clk_cfg_g or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_q  <= 2'd0;
      rd_cnt_q <= 8'd0;
      id_q     <= 32'h0000_0100;
      log_cnt  <= 0;
    end else if (reg_ready_o) begin
      rnd = $random(seed);
      stall_q <= rnd[1:0];  // Next request waits 0 to 3 cycles
      if (reg_write_i) begin
        rd_cnt_q <= 8'd0;   // New run, restart ID progression
        if (!reg_error_o) begin
          log_cnt <= log_cnt + 1;
        end
      end else if ((adv_after_i != 8'd0) && (rd_cnt_q + 8'd1 == adv_after_i)) begin
        rd_cnt_q <= 8'd0;
        id_q     <= id_q + 32'd1;  // Transfer retired
      end else begin
        rd_cnt_q <= rd_cnt_q + 8'd1;
      end
    end else if (reg_valid_i) begin
      stall_q <= stall_q - 2'd1;
    end
  end

endmodule

`default_nettype wire

// File: verification/idma_xif_ctrl_tb.sv
// DMA instruction front end testbench
`default_nettype none

module idma_xif_ctrl_tb import idma_xif_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int         CLK_PERIOD = 20;
  localparam int         N_SCEN     = 6;
  localparam logic [6:0] OPC_BAD    = 7'b1111011;  // Belongs to no unit here

  logic clk_cfg_g = 1'b0;
  logic rst_ni;
  logic clear_i;
  logic issue_valid_i;
  logic rs_valid_i;
  logic [INSTR_W-1:0] instr_i;
  logic [DATA_W-1:0]  rs0_i;
  logic [DATA_W-1:0]  rs1_i;
  logic issue_ready_o;
  logic accept_o;
  logic reg_ready_i;
  logic reg_error_i;
  logic [DATA_W-1:0]  reg_rdata_i;
  logic reg_valid_o;
  logic reg_write_o;
  logic [ADDR_W-1:0]  reg_addr_o;
  logic [DATA_W-1:0]  reg_wdata_o;
  logic direction_o;
  logic start_o;
  logic busy_o;
  logic done_o;
  logic error_o;

  // Responder controls
  logic              err_en;
  logic [ADDR_W-1:0] err_addr;
  logic              zero_id;
  logic [7:0]        adv_after;

  int   seed = 32'h742fb6b5;
  int   rnd;
  int   errors = 0;
  logic ignore_start;  // Next start arrives while busy

  // Expected state, built from the instructions given
  logic [DATA_W-1:0] exp_words [N_CFG_WORDS];
  logic [3:0]        wr_cnt;    // Acknowledged writes in this run
  logic              first_rd;
  logic              launch_exp;
  logic              busy_exp;
  logic              done_exp;
  logic              halted;    // No request until the next start
  logic [DATA_W-1:0] id_exp;

  logic [6:0] opc;
  logic [2:0] f3;
  logic [2:0] lo_idx;
  logic       acc_exp;
  logic       ack;
  logic       err_exp;
  logic       wr_ok;
  logic       rd_ok;

  always #(CLK_PERIOD / 2) clk_cfg_g = ~clk_cfg_g;

  idma_xif_ctrl DUT (
    .clk_cfg_g, .rst_ni, .clear_i,
    .issue_valid_i, .rs_valid_i, .instr_i, .rs0_i, .rs1_i,
    .issue_ready_o, .accept_o,
    .reg_ready_i, .reg_error_i, .reg_rdata_i,
    .reg_valid_o, .reg_write_o, .reg_addr_o, .reg_wdata_o,
    .direction_o, .start_o, .busy_o, .done_o, .error_o
  );

  fe_reg_model RESP (
    .clk_cfg_g, .rst_ni,
    .reg_valid_i (reg_valid_o),
    .reg_write_i (reg_write_o),
    .reg_addr_i  (reg_addr_o),
    .err_en_i    (err_en),
    .err_addr_i  (err_addr),
    .zero_id_i   (zero_id),
    .adv_after_i (adv_after),
    .reg_ready_o (reg_ready_i),
    .reg_error_o (reg_error_i),
    .reg_rdata_o (reg_rdata_i)
  );

  function automatic logic [DATA_W-1:0] pack_conf(logic [INSTR_W-1:0] ins);
    return {22'd0, ins[DIRECTION_OFF], ins[DECOUPLE_R_AW_OFF], ins[DECOUPLE_R_W_OFF],
            ins[SRC_MAX_LOG_LEN_OFF +: 3], ins[DST_MAX_LOG_LEN_OFF +: 3], ins[ND_EN_OFF]};
  endfunction

  // Registers sit 4 bytes apart in write order
  function automatic logic [ADDR_W-1:0] addr_of(logic [3:0] idx);
    return (idx < 4'd7) ? {2'b00, idx, 2'b00} : 8'hFF;
  endfunction

  function automatic logic [INSTR_W-1:0] conf_instr(logic [31:0] r);
    return {r[31:7], OPC_CONF};
  endfunction

  function automatic logic [INSTR_W-1:0] set_instr(logic [2:0] fn);
    return {17'd0, fn, 5'd0, OPC_SET};
  endfunction

  task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
    errors++;
    $display("CHECK FAILED t=%0t %s expected %0h actual %0h", $time, name, exp, act);
  endtask

  task automatic report_problem(string msg);
    errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Expected state tracking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign opc        = instr_i[OPCODE_OFF +: 7];
  assign f3         = instr_i[FUNC3_OFF +: 3];
  assign lo_idx     = {f3[1:0], 1'b1};  // DST, SRC, LEN pairs start at 1, 3, 5
  assign acc_exp    = issue_valid_i && ((opc == OPC_CONF) || (opc == OPC_SET));
  assign launch_exp = first_rd && (wr_cnt == 4'd7);  // All writes done, ID not yet read
  assign ack        = reg_valid_o && reg_ready_i;
  assign err_exp    = ack && (reg_error_i || (launch_exp && reg_rdata_i == '0));
  assign wr_ok      = ack && reg_write_o && !reg_error_i;
  assign rd_ok      = ack && !reg_write_o && !reg_error_i;

  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin
    if (!rst_ni || clear_i) begin
      for (int i = 0; i < N_CFG_WORDS; i++) begin
        exp_words[i] <= '0;
      end
      wr_cnt   <= 4'd7;
      first_rd <= 1'b0;
      busy_exp <= 1'b0;
      done_exp <= 1'b0;
      halted   <= 1'b1;
      id_exp   <= '0;
    end else begin
      done_exp <= 1'b0;
      if (acc_exp && opc == OPC_CONF) exp_words[W_CONF] <= pack_conf(instr_i);
      if (acc_exp && opc == OPC_SET && rs_valid_i && f3 <= 3'd2) begin
        exp_words[lo_idx]        <= rs0_i;
        exp_words[lo_idx + 3'd1] <= rs1_i;
      end
      if (acc_exp && opc == OPC_SET && f3 == F3_START && !ignore_start) begin
        wr_cnt   <= 4'd0;
        first_rd <= 1'b1;
        halted   <= 1'b0;
      end
      if (wr_ok) wr_cnt <= wr_cnt + 4'd1;
      if (err_exp) begin
        busy_exp <= 1'b0;
        first_rd <= 1'b0;
        halted   <= 1'b1;
      end else if (rd_ok && first_rd) begin
        id_exp   <= reg_rdata_i;  // Launch ID
        first_rd <= 1'b0;
        busy_exp <= 1'b1;
      end else if (rd_ok && reg_rdata_i != id_exp) begin
        busy_exp <= 1'b0;
        done_exp <= 1'b1;
        halted   <= 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_accept: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni)
    accept_o == acc_exp)
    else report_mismatch("accept_o", 32'($sampled(acc_exp)), 32'($sampled(accept_o)));
  a_ready: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni)
    issue_ready_o == acc_exp)
    else report_mismatch("issue_ready_o", 32'($sampled(acc_exp)),
                         32'($sampled(issue_ready_o)));
  a_direction: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni)
    direction_o == exp_words[W_CONF][CONF_DIR_BIT])
    else report_mismatch("direction_o", 32'($sampled(exp_words[W_CONF][CONF_DIR_BIT])),
                         32'($sampled(direction_o)));
  a_wr_addr: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni)
    (reg_valid_o && reg_write_o) |-> reg_addr_o == addr_of(wr_cnt))
    else report_mismatch("reg_addr_o", 32'(addr_of($sampled(wr_cnt))),
                         32'($sampled(reg_addr_o)));
  a_wr_data: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni)
    (wr_ok && wr_cnt < 4'd7) |-> reg_wdata_o == exp_words[wr_cnt[2:0]])
    else report_mismatch("reg_wdata_o", $sampled(exp_words[wr_cnt[2:0]]),
                         $sampled(reg_wdata_o));
  a_rd_addr: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni)
    (reg_valid_o && !reg_write_o) |-> reg_addr_o == REG_NEXT_ID_ADDR)
    else report_mismatch("reg_addr_o", 32'(REG_NEXT_ID_ADDR), 32'($sampled(reg_addr_o)));
  a_start: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni)
    start_o == launch_exp)
    else report_mismatch("start_o", 32'($sampled(launch_exp)), 32'($sampled(start_o)));
  a_busy: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni) busy_o == busy_exp)
    else report_mismatch("busy_o", 32'($sampled(busy_exp)), 32'($sampled(busy_o)));
  a_done: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni) done_o == done_exp)
    else report_mismatch("done_o", 32'($sampled(done_exp)), 32'($sampled(done_o)));
  a_error: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni) error_o == err_exp)
    else report_mismatch("error_o", 32'($sampled(err_exp)), 32'($sampled(error_o)));
  a_no_req: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni)
    halted |-> !reg_valid_o)
    else report_problem("register request issued without a start");
  a_log_frozen: assert property (@(posedge clk_cfg_g) disable iff (!rst_ni)
    halted |=> $stable(RESP.log_cnt))
    else report_problem("front-end register written without a start");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic issue_instr(logic [INSTR_W-1:0] ins, logic [DATA_W-1:0] a,
                             logic [DATA_W-1:0] b, logic rsv);
    @(posedge clk_cfg_g);
    issue_valid_i <= 1'b1;
    instr_i       <= ins;
    rs0_i         <= a;
    rs1_i         <= b;
    rs_valid_i    <= rsv;
    @(posedge clk_cfg_g);
    issue_valid_i <= 1'b0;
    rs_valid_i    <= 1'b0;
  endtask

  task automatic program_all();
    issue_instr(conf_instr($random(seed)), '0, '0, 1'b0);
    issue_instr(set_instr(F3_DST), $random(seed), $random(seed), 1'b1);
    issue_instr(set_instr(F3_SRC), $random(seed), $random(seed), 1'b1);
    issue_instr(set_instr(F3_LEN), $random(seed), $random(seed), 1'b1);
  endtask

  // Wait for done or error, then let the bus settle
  task automatic run_start();
    int n;
    n = 0;
    issue_instr(set_instr(F3_START), '0, '0, 1'b0);
    while (!done_o && !error_o && n < 150) begin
      @(posedge clk_cfg_g);
      n++;
    end
    if (n >= 150) report_problem("transfer neither finished nor failed");
    repeat (3) @(posedge clk_cfg_g);
  endtask

  task automatic finish_run();
    $display("Summary: %0d scenarios, %0d errors", N_SCEN, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  initial begin
    int n;
    rst_ni = 1'b0;
    clear_i = 1'b0;
    issue_valid_i = 1'b0;
    rs_valid_i = 1'b0;
    instr_i = '0;
    rs0_i = '0;
    rs1_i = '0;
    err_en = 1'b0;
    err_addr = '0;
    zero_id = 1'b0;
    adv_after = 8'd3;
    ignore_start = 1'b0;
    repeat (8) @(posedge clk_cfg_g);
    rst_ni <= 1'b1;

    // Acceptance, including an unknown opcode and func3
    issue_instr({25'd0, OPC_BAD}, $random(seed), $random(seed), 1'b1);
    issue_instr(conf_instr($random(seed)), '0, '0, 1'b0);
    issue_instr(set_instr(3'd5), $random(seed), $random(seed), 1'b1);

    // Full program, SRC update without valid operands is dropped
    program_all();
    issue_instr(set_instr(F3_SRC), $random(seed), $random(seed), 1'b0);
    run_start();

    zero_id <= 1'b1;  // ID zero at launch
    run_start();
    zero_id <= 1'b0;

    err_en   <= 1'b1;
    err_addr <= REG_SRC_LO_ADDR;
    run_start();
    err_en   <= 1'b0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Start while busy, then clear
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    adv_after <= 8'd0;
    issue_instr(set_instr(F3_START), '0, '0, 1'b0);
    n = 0;
    while (!busy_o && n < 100) begin
      @(posedge clk_cfg_g);
      n++;
    end
    if (n >= 100) report_problem("busy_o never rose after a start");
    ignore_start <= 1'b1;
    issue_instr(set_instr(F3_START), '0, '0, 1'b0);
    ignore_start <= 1'b0;
    repeat (10) @(posedge clk_cfg_g);
    clear_i <= 1'b1;
    @(posedge clk_cfg_g);
    clear_i   <= 1'b0;
    adv_after <= 8'd2;
    issue_instr(set_instr(F3_LEN), $random(seed), $random(seed), 1'b1);
    run_start();

    repeat (2) begin
      program_all();
      rnd = $random(seed);
      adv_after <= {6'd0, rnd[1:0]} + 8'd1;
      run_start();
    end
    finish_run();
  end

  initial begin
    #(N_SCEN * 200 * CLK_PERIOD);
    report_problem("watchdog expired before the tests finished");
    finish_run();
  end

endmodule

`default_nettype wire

// File: idma_xif_ctrl.f
logic/idma_xif_pkg.sv
logic/xif_inst_decoder.sv
logic/dma_cfg_bank.sv
logic/fe_program_fsm.sv
logic/idma_xif_ctrl.sv
verification/fe_reg_model.sv
verification/idma_xif_ctrl_tb.sv

// File: Makefile
TOP = idma_xif_ctrl_tb

.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -f idma_xif_ctrl.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
